// ==== uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // command word from the host
  // write flag and address form the upper byte, sent as the first frame
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  // result handed back to the host after a read
  typedef struct packed {
    logic       err;
    logic [7:0] data;
  } read_resp_t;

  // one received frame, valid while rx_done is high
  typedef struct packed {
    logic       parity_err;
    logic       frame_err;
    logic [7:0] data;
  } rx_status_t;

  // start + 8 data + parity + stop
  localparam int BITS_PER_FRAME_PAR   = 11;
  // start + 8 data + stop
  localparam int BITS_PER_FRAME_NOPAR = 10;

endpackage

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter bit PARITY_EN    = 1'b1
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] tx_byte,
  input  wire        tx_start,
  output logic       tx_busy,
  output logic       tx
);

  localparam int FRAME_BITS = PARITY_EN ? BITS_PER_FRAME_PAR : BITS_PER_FRAME_NOPAR;
  localparam int CNT_W      = $clog2(CLKS_PER_BIT + 1);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0]       BIT_LAST = 4'(FRAME_BITS - 1);

  logic [BITS_PER_FRAME_PAR-1:0] frame_q;
  logic [BITS_PER_FRAME_PAR-1:0] frame_load;
  logic [CNT_W-1:0]              clk_cnt;
  logic [3:0]                    bit_cnt;
  logic                          parity_bit;

  // odd parity over the data byte
  assign parity_bit = ~^tx_byte;

  // lsb goes out first, so the start bit sits at bit 0
  // without parity the top bit is just extra idle level
  assign frame_load = PARITY_EN ? {1'b1, parity_bit, tx_byte, 1'b0}
                                : {2'b11, tx_byte, 1'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_q <= '1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_start && !tx_busy) begin
      frame_q <= frame_load;
      tx_busy <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_busy) begin
      if (clk_cnt == CNT_LAST) begin
        clk_cnt <= '0;
        // shift in ones so the line idles high once the frame is out
        frame_q <= {1'b1, frame_q[BITS_PER_FRAME_PAR-1:1]};
        if (bit_cnt == BIT_LAST) begin
          tx_busy <= 1'b0;
          bit_cnt <= '0;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  assign tx = frame_q[0];

  // controller must wait for the previous frame before starting a new one
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  );

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter bit PARITY_EN    = 1'b1
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        rx_en,
  output logic       rx_started,
  output logic       rx_done,
  output rx_status_t rx_status
);

  localparam int FRAME_BITS = PARITY_EN ? BITS_PER_FRAME_PAR : BITS_PER_FRAME_NOPAR;
  localparam int CNT_W      = $clog2(CLKS_PER_BIT + 1);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [3:0]       BIT_PAR  = 4'd9;
  localparam logic [3:0]       BIT_STOP = 4'(FRAME_BITS - 1);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             start_edge;
  logic             sample;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [7:0]       shift_q;
  logic             par_err_q;
  rx_status_t       status_q;

  // two-flop synchronizer plus one more stage for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync;
  assign sample     = rx_started && (clk_cnt == CNT_MID);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_started <= 1'b0;
      rx_done    <= 1'b0;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
    end else begin
      rx_done <= 1'b0;
      if (!rx_started) begin
        // count re-phases on every accepted start edge
        if (rx_en && start_edge) begin
          rx_started <= 1'b1;
          clk_cnt    <= '0;
          bit_cnt    <= '0;
        end
      end else begin
        clk_cnt <= (clk_cnt == CNT_LAST) ? '0 : clk_cnt + 1'b1;
        if (sample) begin
          bit_cnt <= bit_cnt + 4'd1;
          if (bit_cnt == 4'd0 && rx_sync) begin
            // glitch, start bit gone by mid-bit
            rx_started <= 1'b0;
          end else if (bit_cnt == BIT_STOP) begin
            rx_started <= 1'b0;
            rx_done    <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
        shift_q <= {rx_sync, shift_q[7:1]};
      end
      // odd parity fails when data plus parity has an even count of ones
      if (PARITY_EN && bit_cnt == BIT_PAR) begin
        par_err_q <= ~^{shift_q, rx_sync};
      end
      if (bit_cnt == BIT_STOP) begin
        status_q.parity_err <= PARITY_EN ? par_err_q : 1'b0;
        status_q.frame_err  <= !rx_sync;
        status_q.data       <= shift_q;
      end
    end
  end

  assign rx_status = status_q;

  a_done_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_done |=> !rx_done
  );

endmodule

`default_nettype wire

// ==== uart_cmd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT    = 434,
  parameter int RX_TIMEOUT_BITS = 32
) (
  input  wire        clk,
  input  wire        rst_n,
  input  uart_cmd_t  cmd_in,
  input  wire        cmd_vld,
  output logic       cmd_rdy,
  output logic [7:0] tx_byte,
  output logic       tx_start,
  input  wire        tx_busy,
  output logic       rx_en,
  input  wire        rx_started,
  input  wire        rx_done,
  input  rx_status_t rx_status,
  output read_resp_t read_data,
  output logic       read_vld
);

  localparam int TO_CYCLES = RX_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int TO_W      = $clog2(TO_CYCLES + 1);

  localparam logic [TO_W-1:0] TO_LAST = TO_W'(TO_CYCLES - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_WAIT
  } state_t;

  state_t          state;
  uart_cmd_t       cmd_q;
  logic            busy_q;
  logic            tx_done;
  logic            accept;
  logic            timeout;
  logic [TO_W-1:0] to_cnt;

  // a frame is finished when tx_busy falls
  assign tx_done = busy_q && !tx_busy;
  assign accept  = cmd_vld && cmd_rdy;
  assign timeout = (state == S_WAIT) && !rx_started && !rx_done && (to_cnt == TO_LAST);
  assign rx_en   = (state == S_WAIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      busy_q   <= 1'b0;
      to_cnt   <= '0;
    end else begin
      busy_q   <= tx_busy;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            state    <= S_ADDR;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
          end
        end
        S_ADDR: begin
          if (tx_done) begin
            if (cmd_q.write) begin
              state    <= S_DATA;
              tx_start <= 1'b1;
            end else begin
              state  <= S_WAIT;
              to_cnt <= '0;
            end
          end
        end
        S_DATA: begin
          if (tx_done) begin
            state   <= S_IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        S_WAIT: begin
          if (rx_done || timeout) begin
            state    <= S_IDLE;
            cmd_rdy  <= 1'b1;
            read_vld <= 1'b1;
          end else if (!rx_started) begin
            // timer holds while a frame is coming in
            to_cnt <= to_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= cmd_in;
      tx_byte <= {cmd_in.write, cmd_in.addr};
    end else if (state == S_ADDR && tx_done) begin
      tx_byte <= cmd_q.data;
    end
    if (rx_done && state == S_WAIT) begin
      read_data.err  <= rx_status.parity_err | rx_status.frame_err;
      read_data.data <= rx_status.data;
    end else if (timeout) begin
      read_data.err  <= 1'b1;
      read_data.data <= '0;
    end
  end

  a_rdy_only_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state != S_IDLE) |-> !cmd_rdy
  );

endmodule

`default_nettype wire

// ==== uart_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT    = 434,
  parameter bit PARITY_EN       = 1'b1,
  parameter int RX_TIMEOUT_BITS = 32
) (
  input  wire        clk,
  input  wire        rst_n,
  input  uart_cmd_t  cmd_in,
  input  wire        cmd_vld,
  output logic       cmd_rdy,
  input  wire        rx,
  output logic       tx,
  output read_resp_t read_data,
  output logic       read_vld
);

  logic [7:0] tx_byte;
  logic       tx_start;
  logic       tx_busy;
  logic       rx_en;
  logic       rx_started;
  logic       rx_done;
  rx_status_t rx_status;

  uart_cmd_ctrl #(
    .CLKS_PER_BIT    (CLKS_PER_BIT),
    .RX_TIMEOUT_BITS (RX_TIMEOUT_BITS)
  ) i_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .tx_byte    (tx_byte),
    .tx_start   (tx_start),
    .tx_busy    (tx_busy),
    .rx_en      (rx_en),
    .rx_started (rx_started),
    .rx_done    (rx_done),
    .rx_status  (rx_status),
    .read_data  (read_data),
    .read_vld   (read_vld)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) i_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_en      (rx_en),
    .rx_started (rx_started),
    .rx_done    (rx_done),
    .rx_status  (rx_status)
  );

endmodule

`default_nettype wire

// ==== tb_uart_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uart_cmd_top
  import uart_cmd_pkg::*;
();

  localparam int CLKS_PER_BIT     = 16;
  localparam int RX_TIMEOUT_BITS  = 8;
  localparam int FRAME_CLKS       = BITS_PER_FRAME_PAR * CLKS_PER_BIT;
  localparam int READ_LIMIT       = RX_TIMEOUT_BITS * CLKS_PER_BIT + 2 * FRAME_CLKS;
  localparam int NUM_CMDS         = 13;
  localparam int WATCHDOG_NS      = NUM_CMDS * (2 * 11 + 8 + 11 + 10) * CLKS_PER_BIT * 20 * 2;
  localparam int REPLY_GOOD       = 0;
  localparam int REPLY_BAD_PARITY = 1;
  localparam int REPLY_NONE       = 2;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  read_resp_t read_data;
  logic       read_vld;

  integer     seed;
  int         errors       = 0;
  int         tests_run    = 0;
  int         tests_failed = 0;
  int         rd_count     = 0;
  read_resp_t rd_last;
  logic       write_busy   = 1'b0;
  logic       reply_wait   = 1'b0;

  uart_cmd_top #(
    .CLKS_PER_BIT    (CLKS_PER_BIT),
    .PARITY_EN       (1'b1),
    .RX_TIMEOUT_BITS (RX_TIMEOUT_BITS)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_vld  (read_vld)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("run stopped by the watchdog, a test never finished");
    $display(">>> FAIL");
    $finish;
  end

  // read results are collected mid-cycle
  always @(negedge clk) begin
    if (rst_n && read_vld) begin
      rd_count <= rd_count + 1;
      rd_last  <= read_data;
    end
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  a_line_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd_rdy || reply_wait) |-> tx
  ) else report_failure("tx left idle level while no frame was due");

  a_vld_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  ) else report_failure("read_vld lasted longer than one cycle");

  a_vld_with_rdy: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |-> cmd_rdy
  ) else report_failure("cmd_rdy was not high together with read_vld");

  a_write_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    write_busy |-> (!cmd_rdy && !read_vld)
  ) else report_failure("cmd_rdy or read_vld high while a write was running");

  function automatic uart_cmd_t rand_cmd(input logic wr);
    uart_cmd_t c;
    c       = 16'($random(seed));
    c.write = wr;
    return c;
  endfunction

  task automatic send_cmd(input uart_cmd_t cmd);
    int n;
    @(posedge clk);
    #2;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    n       = 0;
    @(negedge clk);
    while (!cmd_rdy && n < 4 * FRAME_CLKS) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) report_failure("command was never accepted, cmd_rdy stayed low");
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
  endtask

  // remote device model samples tx at mid-bit
  task automatic receive_frame(output logic [7:0] data);
    int   i;
    logic par;
    logic exp_par;
    data = '0;
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    assert (tx === 1'b0) else report_failure("start bit on tx did not last to mid-bit");
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = tx;
    // odd total of ones over data and parity
    exp_par = ($countones(data) % 2 == 0);
    check_value("tx parity bit", par, exp_par);
    repeat (CLKS_PER_BIT) @(negedge clk);
    assert (tx === 1'b1) else report_failure("stop bit on tx was not high");
  endtask

  task automatic drive_reply(input logic [7:0] data, input logic bad_parity);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    @(posedge clk);
    for (i = 0; i < BITS_PER_FRAME_PAR; i++) begin
      #2;
      rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  task automatic check_write_frames(input uart_cmd_t cmd);
    logic [7:0] b;
    write_busy = 1'b1;
    receive_frame(b);
    check_value("tx frame 1", b, cmd[15:8]);
    receive_frame(b);
    check_value("tx frame 2", b, cmd[7:0]);
    write_busy = 1'b0;
  endtask

  task automatic run_write(input uart_cmd_t cmd);
    int n0;
    int n;
    send_cmd(cmd);
    n0 = rd_count;
    check_write_frames(cmd);
    n = 0;
    while (!cmd_rdy && n < CLKS_PER_BIT + 4) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) report_failure("cmd_rdy did not return after the data frame");
    check_value("read_vld count", rd_count - n0, 0);
  endtask

  task automatic run_read(input uart_cmd_t cmd, input logic [7:0] reply, input int mode,
                          output read_resp_t resp);
    logic [7:0] b;
    int         n0;
    int         n;
    send_cmd(cmd);
    n0 = rd_count;
    receive_frame(b);
    check_value("tx address frame", b, cmd[15:8]);
    reply_wait = 1'b1;
    if (mode != REPLY_NONE) begin
      repeat (2 * CLKS_PER_BIT) @(posedge clk);
      drive_reply(reply, mode == REPLY_BAD_PARITY);
    end
    n = 0;
    while (rd_count == n0 && n < READ_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (rd_count == n0) report_failure("read_vld never came for a read command");
    reply_wait = 1'b0;
    check_value("read_vld count", rd_count - n0, 1);
    resp = rd_last;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  initial begin
    uart_cmd_t  c;
    uart_cmd_t  c2;
    read_resp_t r;
    logic [7:0] reply;
    int         e0;
    int         i;
    seed    = 32'hc870e1c5;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    e0 = errors;
    @(negedge clk);
    check_value("tx", tx, 1);
    check_value("cmd_rdy", cmd_rdy, 1);
    check_value("read_vld", read_vld, 0);
    finish_test("after reset", e0);

    e0 = errors;
    for (i = 0; i < 4; i++) begin
      run_write(rand_cmd(1'b1));
    end
    finish_test("random writes", e0);

    e0 = errors;
    for (i = 0; i < 4; i++) begin
      c     = rand_cmd(1'b0);
      reply = 8'($random(seed));
      run_read(c, reply, REPLY_GOOD, r);
      check_value("read_data.err", r.err, 0);
      check_value("read_data.data", r.data, reply);
    end
    finish_test("random reads", e0);

    e0 = errors;
    reply = 8'($random(seed));
    run_read(rand_cmd(1'b0), reply, REPLY_BAD_PARITY, r);
    check_value("read_data.err", r.err, 1);
    finish_test("reply with bad parity", e0);

    e0 = errors;
    run_read(rand_cmd(1'b0), 8'h00, REPLY_NONE, r);
    check_value("read_data.err", r.err, 1);
    check_value("read_data.data", r.data, 0);
    run_write(rand_cmd(1'b1));
    finish_test("read with no reply", e0);

    // second word waits on cmd_vld for the whole first write
    e0 = errors;
    c  = rand_cmd(1'b1);
    c2 = rand_cmd(1'b1);
    if (c2.addr == c.addr) c2.addr = ~c2.addr;
    if (c2.data == c.data) c2.data = ~c2.data;
    send_cmd(c);
    cmd_in  = c2;
    cmd_vld = 1'b1;
    check_write_frames(c);
    run_write(c2);
    finish_test("command during write", e0);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_cmd.f ====
uart_cmd_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart_cmd_top.sv
tb_uart_cmd_top.sv
